// ==== source/iw_consts.svh ====
`ifndef IW_CONSTS_SVH
`define IW_CONSTS_SVH

// window geometry
`define IW_SIZE          8
// only the two lowest slots may issue
`define IW_EXEC_SLOTS    2
// slots wired to the register manager
`define IW_RESOLVE_SLOTS 4
// decoded entries land here
`define IW_DECODE_BASE   (`IW_SIZE-1)
`define IW_SLOT_ID_W     3

// datapath widths
`define IW_WORD_W        32
`define IW_VREG_W        5
`define IW_PREG_W        6
// one-hot branch context tag
`define IW_CONTEXT_W     4
// one-hot alu, mem, jump, branch; all zero is a nop
`define IW_EXEC_TYPE_W   4
// func3 and func7 merged
`define IW_OP_W          10

`endif

// ==== source/iw_pkg.sv ====
`include "iw_consts.svh"

package iw_pkg;

    // decoded instruction as handed over by decode
    typedef struct packed {
        logic [`IW_EXEC_TYPE_W-1:0] exec_type;
        logic [`IW_OP_W-1:0]        op;
        logic [`IW_CONTEXT_W-1:0]   context_tag;
        logic [`IW_VREG_W-1:0]      va_rs1;
        logic [`IW_VREG_W-1:0]      va_rs2;
        logic [`IW_VREG_W-1:0]      va_rd;
        logic                       need_rs1;
        logic                       need_rs2;
        logic                       need_rd;
        logic [`IW_WORD_W-1:0]      imm;
    } dec_info_t;

    // one window slot
    typedef struct packed {
        logic [`IW_EXEC_TYPE_W-1:0] exec_type;
        logic [`IW_OP_W-1:0]        op;
        logic [`IW_CONTEXT_W-1:0]   context_tag;
        logic [`IW_VREG_W-1:0]      va_rs1;
        logic [`IW_VREG_W-1:0]      va_rs2;
        logic [`IW_VREG_W-1:0]      va_rd;
        logic [`IW_WORD_W-1:0]      d_rs1;
        logic [`IW_WORD_W-1:0]      d_rs2;
        logic [`IW_PREG_W-1:0]      pa_rd;
        logic                       rs1_ready;
        logic                       rs2_ready;
        logic                       rd_ready;
    } iw_entry_t;

    // request to the register manager
    typedef struct packed {
        logic                       rs1_order;
        logic [`IW_VREG_W-1:0]      va_rs1;
        logic                       rs2_order;
        logic [`IW_VREG_W-1:0]      va_rs2;
        logic                       rd_order;
        logic [`IW_VREG_W-1:0]      va_rd;
        logic [`IW_CONTEXT_W-1:0]   context_tag;
    } reg_req_t;

    // same-cycle answer, one ready bit per field
    typedef struct packed {
        logic                       rs1_ready;
        logic [`IW_WORD_W-1:0]      rs1;
        logic                       rs2_ready;
        logic [`IW_WORD_W-1:0]      rs2;
        logic                       rd_ready;
        logic [`IW_PREG_W-1:0]      rd;
    } reg_resp_t;

    // packet offered to the execution unit
    typedef struct packed {
        logic [`IW_EXEC_TYPE_W-1:0] exec_type;
        logic [`IW_OP_W-1:0]        op;
        logic [`IW_PREG_W-1:0]      pa_rd;
        logic [`IW_WORD_W-1:0]      d_rs1;
        logic [`IW_WORD_W-1:0]      d_rs2;
        logic [`IW_CONTEXT_W-1:0]   context_tag;
    } exec_info_t;

endpackage

// ==== source/issue_select.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module issue_select (
    input  iw_pkg::iw_entry_t   slot_entry [`IW_SIZE],
    input  logic [`IW_SIZE-1:0] slot_valid,
    input  logic                accepted,
    output logic                order,
    output iw_pkg::exec_info_t  e_exec_info,
    output logic [`IW_SIZE-1:0] keep_valid
);
    import iw_pkg::*;

    logic [`IW_EXEC_SLOTS-1:0] ready;
    logic [`IW_SLOT_ID_W-1:0]  sel_id;
    iw_entry_t                 sel;

    // all operands known and not a nop
    always_comb begin
        for (int i = 0; i < `IW_EXEC_SLOTS; i++) begin
            ready[i] = slot_valid[i]
                     & slot_entry[i].rs1_ready
                     & slot_entry[i].rs2_ready
                     & slot_entry[i].rd_ready
                     & (|slot_entry[i].exec_type);
        end
    end

    // scan from the top so the lowest ready slot wins
    always_comb begin
        order  = 1'b0;
        sel_id = '0;
        for (int i = `IW_EXEC_SLOTS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                order  = 1'b1;
                sel_id = i[`IW_SLOT_ID_W-1:0];
            end
        end
    end

    assign sel = slot_entry[sel_id];

    always_comb begin
        e_exec_info.exec_type   = sel.exec_type;
        e_exec_info.op          = sel.op;
        e_exec_info.pa_rd       = sel.pa_rd;
        e_exec_info.d_rs1       = sel.d_rs1;
        e_exec_info.d_rs2       = sel.d_rs2;
        e_exec_info.context_tag = sel.context_tag;
    end

    // issued entry leaves the window only when exec takes it
    always_comb begin
        keep_valid = slot_valid;
        if (order && accepted) begin
            keep_valid[sel_id] = 1'b0;
        end
    end

endmodule

// ==== source/window_compact.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module window_compact (
    input  logic [`IW_SIZE-1:0]      keep_valid,
    output logic [`IW_SLOT_ID_W-1:0] src_id [`IW_SIZE],
    output logic [`IW_SIZE-1:0]      next_valid
);

    // reach[k][j] is set once slots 0..j hold more than k survivors
    logic [`IW_SIZE-1:0] reach [`IW_SIZE];
    logic [`IW_SIZE-1:0] src_onehot [`IW_SIZE];

    always_comb begin
        for (int k = 0; k < `IW_SIZE; k++) begin
            for (int j = 0; j < `IW_SIZE; j++) begin
                if (j == 0) begin
                    reach[k][j] = (k == 0) ? keep_valid[0] : 1'b0;
                end else if (k == 0) begin
                    reach[k][j] = reach[k][j-1] | keep_valid[j];
                end else begin
                    reach[k][j] = reach[k][j-1]
                                | (reach[k-1][j-1] & keep_valid[j]);
                end
            end
        end
    end

    // rising edge of each row marks the k-th survivor
    always_comb begin
        for (int k = 0; k < `IW_SIZE; k++) begin
            src_onehot[k] = reach[k] & ~(reach[k] << 1);
            next_valid[k] = |src_onehot[k];
        end
    end

    // one-hot to index; empty rows point at slot 0
    always_comb begin
        for (int k = 0; k < `IW_SIZE; k++) begin
            src_id[k] = '0;
            for (int j = 0; j < `IW_SIZE; j++) begin
                if (src_onehot[k][j]) begin
                    src_id[k] = j[`IW_SLOT_ID_W-1:0];
                end
            end
        end
    end

endmodule

// ==== source/operand_resolve.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module operand_resolve (
    input  iw_pkg::iw_entry_t        slot_entry [`IW_SIZE],
    input  logic [`IW_SLOT_ID_W-1:0] src_id [`IW_SIZE],
    input  logic [`IW_SIZE-1:0]      next_valid,
    input  logic                     branch_hazard,
    input  logic [`IW_CONTEXT_W-1:0] hazard_context,
    output iw_pkg::reg_req_t         r_inst_vreg [`IW_RESOLVE_SLOTS],
    input  iw_pkg::reg_resp_t        r_inst_d_r [`IW_RESOLVE_SLOTS],
    output iw_pkg::iw_entry_t        next_entry [`IW_SIZE],
    output logic [`IW_SIZE-1:0]      next_valid_out,
    output logic                     accept_able
);
    import iw_pkg::*;

    iw_entry_t           moved [`IW_SIZE];
    logic [`IW_SIZE-1:0] kill;

    // gather, then drop anything on the mispredicted path
    always_comb begin
        for (int k = 0; k < `IW_SIZE; k++) begin
            moved[k]          = slot_entry[src_id[k]];
            kill[k]           = branch_hazard
                              & (|(hazard_context & moved[k].context_tag));
            next_valid_out[k] = next_valid[k] & ~kill[k];
        end
    end

    // lower slots ask for whatever is still missing
    always_comb begin
        for (int k = 0; k < `IW_RESOLVE_SLOTS; k++) begin
            r_inst_vreg[k].rs1_order   = next_valid_out[k] & ~moved[k].rs1_ready;
            r_inst_vreg[k].va_rs1      = moved[k].va_rs1;
            r_inst_vreg[k].rs2_order   = next_valid_out[k] & ~moved[k].rs2_ready;
            r_inst_vreg[k].va_rs2      = moved[k].va_rs2;
            r_inst_vreg[k].rd_order    = next_valid_out[k] & ~moved[k].rd_ready;
            r_inst_vreg[k].va_rd       = moved[k].va_rd;
            r_inst_vreg[k].context_tag = moved[k].context_tag;
        end
    end

    always_comb begin
        for (int k = 0; k < `IW_SIZE; k++) begin
            next_entry[k] = moved[k];
        end
        // merge answered fields
        for (int k = 0; k < `IW_RESOLVE_SLOTS; k++) begin
            if (r_inst_vreg[k].rs1_order && r_inst_d_r[k].rs1_ready) begin
                next_entry[k].d_rs1     = r_inst_d_r[k].rs1;
                next_entry[k].rs1_ready = 1'b1;
            end
            if (r_inst_vreg[k].rs2_order && r_inst_d_r[k].rs2_ready) begin
                next_entry[k].d_rs2     = r_inst_d_r[k].rs2;
                next_entry[k].rs2_ready = 1'b1;
            end
            if (r_inst_vreg[k].rd_order && r_inst_d_r[k].rd_ready) begin
                next_entry[k].pa_rd    = r_inst_d_r[k].rd;
                next_entry[k].rd_ready = 1'b1;
            end
        end
    end

    // top slot free after removal, compaction and kill
    assign accept_able = ~next_valid_out[`IW_DECODE_BASE];

endmodule

// ==== source/slot_array.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module slot_array (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     d_done,
    input  iw_pkg::dec_info_t        d_dec_exec_info,
    input  iw_pkg::iw_entry_t        next_entry [`IW_SIZE],
    input  logic [`IW_SIZE-1:0]      next_valid,
    input  logic                     branch_hazard,
    input  logic [`IW_CONTEXT_W-1:0] hazard_context,
    output iw_pkg::iw_entry_t        slot_entry [`IW_SIZE],
    output logic [`IW_SIZE-1:0]      slot_valid
);
    import iw_pkg::*;

    iw_entry_t dec_entry;
    logic      dec_kill;
    logic      dec_take;

    // decoded entry to window entry
    always_comb begin
        dec_entry.exec_type   = d_dec_exec_info.exec_type;
        dec_entry.op          = d_dec_exec_info.op;
        dec_entry.context_tag = d_dec_exec_info.context_tag;
        dec_entry.va_rs1      = d_dec_exec_info.va_rs1;
        dec_entry.va_rs2      = d_dec_exec_info.va_rs2;
        dec_entry.va_rd       = d_dec_exec_info.va_rd;
        // unneeded operands are known right away
        dec_entry.rs1_ready   = ~d_dec_exec_info.need_rs1;
        dec_entry.rs2_ready   = ~d_dec_exec_info.need_rs2;
        dec_entry.rd_ready    = ~d_dec_exec_info.need_rd;
        dec_entry.d_rs1       = '0;
        dec_entry.d_rs2       = d_dec_exec_info.need_rs2 ? '0 : d_dec_exec_info.imm;
        dec_entry.pa_rd       = '0;
    end

    // new entry already on a squashed path
    assign dec_kill = branch_hazard
                    & (|(hazard_context & d_dec_exec_info.context_tag));
    assign dec_take = d_done & ~next_valid[`IW_DECODE_BASE];

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            slot_valid[`IW_DECODE_BASE-1:0] <= next_valid[`IW_DECODE_BASE-1:0];
            slot_valid[`IW_DECODE_BASE] <= next_valid[`IW_DECODE_BASE]
                                         | (dec_take & ~dec_kill);
        end
    end

    // payload follows the valid flags
    always_ff @(posedge clk) begin
        for (int k = 0; k < `IW_DECODE_BASE; k++) begin
            slot_entry[k] <= next_entry[k];
        end
        if (next_valid[`IW_DECODE_BASE]) begin
            slot_entry[`IW_DECODE_BASE] <= next_entry[`IW_DECODE_BASE];
        end else begin
            slot_entry[`IW_DECODE_BASE] <= dec_entry;
        end
    end

endmodule

// ==== source/inst_window.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module inst_window (
    input  logic                     clk,
    input  logic                     rst,

    // to decode
    output logic                     accept_able,

    // from context manager
    input  logic                     branch_hazard,
    input  logic [`IW_CONTEXT_W-1:0] hazard_context,

    // from decode
    input  logic                     d_done,
    input  iw_pkg::dec_info_t        d_dec_exec_info,

    // register manager, answered in the same cycle
    output iw_pkg::reg_req_t         r_inst_vreg [`IW_RESOLVE_SLOTS],
    input  iw_pkg::reg_resp_t        r_inst_d_r [`IW_RESOLVE_SLOTS],

    // exec
    output logic                     order,
    input  logic                     accepted,
    output iw_pkg::exec_info_t       e_exec_info
);
    import iw_pkg::*;

    iw_entry_t                slot_entry [`IW_SIZE];
    iw_entry_t                next_entry [`IW_SIZE];
    logic [`IW_SIZE-1:0]      slot_valid;
    logic [`IW_SIZE-1:0]      keep_valid;
    logic [`IW_SIZE-1:0]      compact_valid;
    logic [`IW_SIZE-1:0]      next_valid;
    logic [`IW_SLOT_ID_W-1:0] src_id [`IW_SIZE];

    slot_array u_slot_array (
        .clk             (clk),
        .rst             (rst),
        .d_done          (d_done),
        .d_dec_exec_info (d_dec_exec_info),
        .next_entry      (next_entry),
        .next_valid      (next_valid),
        .branch_hazard   (branch_hazard),
        .hazard_context  (hazard_context),
        .slot_entry      (slot_entry),
        .slot_valid      (slot_valid)
    );

    issue_select u_issue_select (
        .slot_entry  (slot_entry),
        .slot_valid  (slot_valid),
        .accepted    (accepted),
        .order       (order),
        .e_exec_info (e_exec_info),
        .keep_valid  (keep_valid)
    );

    window_compact u_window_compact (
        .keep_valid (keep_valid),
        .src_id     (src_id),
        .next_valid (compact_valid)
    );

    operand_resolve u_operand_resolve (
        .slot_entry     (slot_entry),
        .src_id         (src_id),
        .next_valid     (compact_valid),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .r_inst_vreg    (r_inst_vreg),
        .r_inst_d_r     (r_inst_d_r),
        .next_entry     (next_entry),
        .next_valid_out (next_valid),
        .accept_able    (accept_able)
    );

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module tb_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     d_done,
    input  iw_pkg::dec_info_t        d_dec_exec_info,
    input  logic                     accept_able,
    input  logic                     branch_hazard,
    input  logic [`IW_CONTEXT_W-1:0] hazard_context,
    input  logic                     order,
    input  logic                     accepted,
    input  iw_pkg::exec_info_t       e_exec_info,
    input  logic [31:0]              vreg_ready,
    input  logic [`IW_WORD_W-1:0]    vreg_val [32],
    output int                       mismatch_count,
    output int                       error_count,
    output int                       pending
);
    import iw_pkg::*;

    typedef struct packed {
        dec_info_t dec;
        logic      all_ready;
    } model_entry_t;

    // live instructions in program order
    model_entry_t window_q [$];
    model_entry_t new_entry;
    logic         first_cycle;
    int           stall_caps;

    function automatic exec_info_t expected_exec(input dec_info_t d);
        exec_info_t e;
        e.exec_type   = d.exec_type;
        e.op          = d.op;
        e.context_tag = d.context_tag;
        e.d_rs1       = d.need_rs1 ? vreg_val[d.va_rs1] : '0;
        e.d_rs2       = d.need_rs2 ? vreg_val[d.va_rs2] : d.imm;
        e.pa_rd       = d.need_rd ? 6'(d.va_rd) + 6'd32 : '0;
        return e;
    endfunction

    function automatic logic regs_ready(input dec_info_t d);
        return (!d.need_rs1 || vreg_ready[d.va_rs1])
            && (!d.need_rs2 || vreg_ready[d.va_rs2])
            && (!d.need_rd || vreg_ready[d.va_rd]);
    endfunction

    task automatic report_field(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (exp !== got) begin
            $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, got);
            mismatch_count++;
        end
    endtask

    task automatic check_issue();
        exec_info_t exp0;
        int         pick;
        pick = -1;
        if (window_q.size() == 0) begin
            $display("Error at time %0t: exec took an instruction while none was pending",
                     $time);
            error_count++;
            return;
        end
        exp0 = expected_exec(window_q[0].dec);
        if (e_exec_info == exp0) begin
            pick = 0;
        end else if (window_q.size() > 1 && e_exec_info == expected_exec(window_q[1].dec)) begin
            pick = 1;
            if (window_q[0].all_ready && window_q[1].all_ready) begin
                $display("Error at time %0t: a younger ready instruction issued first", $time);
                error_count++;
            end
        end
        if (pick < 0) begin
            report_field("e_exec_info.exec_type", 32'(exp0.exec_type), 32'(e_exec_info.exec_type));
            report_field("e_exec_info.op", 32'(exp0.op), 32'(e_exec_info.op));
            report_field("e_exec_info.pa_rd", 32'(exp0.pa_rd), 32'(e_exec_info.pa_rd));
            report_field("e_exec_info.d_rs1", exp0.d_rs1, e_exec_info.d_rs1);
            report_field("e_exec_info.d_rs2", exp0.d_rs2, e_exec_info.d_rs2);
            report_field("e_exec_info.context_tag", 32'(exp0.context_tag),
                         32'(e_exec_info.context_tag));
            pick = 0;
        end
        if (!regs_ready(window_q[pick].dec)) begin
            $display("Error at time %0t: issued before its registers were ready", $time);
            error_count++;
        end
        window_q.delete(pick);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            window_q.delete();
            first_cycle    = 1'b1;
            stall_caps     = 0;
            mismatch_count = 0;
            error_count    = 0;
        end else begin
            if (first_cycle) begin
                report_field("order", 32'd0, 32'(order));
                first_cycle = 1'b0;
            end
            if (order && accepted) begin
                check_issue();
            end
            // issue at this edge goes out before the flush
            if (branch_hazard) begin
                for (int i = window_q.size() - 1; i >= 0; i--) begin
                    if (|(window_q[i].dec.context_tag & hazard_context)) begin
                        window_q.delete(i);
                    end
                end
            end
            // top slot is free when the survivors leave a hole
            report_field("accept_able", 32'(window_q.size() < `IW_SIZE), 32'(accept_able));
            if ((order && accepted) || branch_hazard) begin
                stall_caps = 0;
            end
            if (d_done && accept_able) begin
                stall_caps = stall_caps + 1;
                if (!(branch_hazard && |(hazard_context & d_dec_exec_info.context_tag))) begin
                    new_entry.dec       = d_dec_exec_info;
                    new_entry.all_ready = regs_ready(d_dec_exec_info);
                    window_q.push_back(new_entry);
                end
            end
            if (stall_caps == `IW_SIZE + 1) begin
                $display("Error at time %0t: more than %0d entries taken while exec stalled",
                         $time, `IW_SIZE);
                error_count++;
            end
            if (window_q.size() > `IW_SIZE) begin
                $display("Error at time %0t: window holds more entries than it has slots",
                         $time);
                error_count++;
            end
            pending = window_q.size();
        end
    end

endmodule

// ==== testbench/tb_inst_window.sv ====
`timescale 1ns/1ps
`include "iw_consts.svh"

module tb_inst_window;
    import iw_pkg::*;

    localparam int NUM_INST    = 400;
    localparam int WAIT_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 3000;

    logic                     clk;
    logic                     rst;
    logic                     accept_able;
    logic                     branch_hazard;
    logic [`IW_CONTEXT_W-1:0] hazard_context;
    logic                     d_done;
    dec_info_t                d_dec_exec_info;
    reg_req_t                 r_inst_vreg [`IW_RESOLVE_SLOTS];
    reg_resp_t                r_inst_d_r [`IW_RESOLVE_SLOTS];
    logic                     order;
    logic                     accepted;
    exec_info_t               e_exec_info;

    // register manager table, one entry per vreg
    logic [31:0]              vreg_ready;
    logic [`IW_WORD_W-1:0]    vreg_val [32];

    logic [31:0]              lfsr;
    logic                     took;
    logic                     timed_out;
    int                       hold_left;
    int                       mismatch_count;
    int                       error_count;
    int                       pending;

    inst_window DUT (.*);

    tb_checker u_checker (.*);

    // same-cycle answers from the table, preg is vreg plus 32
    for (genvar k = 0; k < `IW_RESOLVE_SLOTS; k++) begin : g_resp
        assign r_inst_d_r[k] = {vreg_ready[r_inst_vreg[k].va_rs1],
                                vreg_val[r_inst_vreg[k].va_rs1],
                                vreg_ready[r_inst_vreg[k].va_rs2],
                                vreg_val[r_inst_vreg[k].va_rs2],
                                vreg_ready[r_inst_vreg[k].va_rd],
                                6'(r_inst_vreg[k].va_rd) + 6'd32};
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic new_instruction();
        logic [31:0] r;
        dec_info_t   d;
        r = rand_bits(2);
        d.exec_type = '0;
        d.exec_type[r[1:0]] = 1'b1;
        r = rand_bits(`IW_OP_W);
        d.op = r[`IW_OP_W-1:0];
        r = rand_bits(2);
        d.context_tag = '0;
        d.context_tag[r[1:0]] = 1'b1;
        r = rand_bits(18);
        d.va_rs1   = r[4:0];
        d.va_rs2   = r[9:5];
        d.va_rd    = r[14:10];
        d.need_rs1 = r[15];
        d.need_rs2 = r[16];
        d.need_rd  = r[17];
        d.imm      = rand_bits(32);
        d_dec_exec_info = d;
        d_done = 1'b1;
    endtask

    // capture is seen at the falling edge, new inputs go out 1 ns after the rising one
    task automatic step_cycle();
        logic [31:0] r;
        logic [4:0]  idx;
        @(negedge clk);
        took = d_done & accept_able;
        @(posedge clk);
        #1;
        if (took) begin
            d_done = 1'b0;
        end
        if (hold_left > 0) begin
            accepted  = 1'b0;
            hold_left = hold_left - 1;
        end else begin
            r        = rand_bits(2);
            accepted = (r[1:0] != 2'b00);
        end
        // one vreg per cycle turns ready, value fixed from then on
        r   = rand_bits(5);
        idx = r[4:0];
        if (!vreg_ready[idx]) begin
            vreg_val[idx]   = rand_bits(32);
            vreg_ready[idx] = 1'b1;
        end
        r              = rand_bits(6);
        branch_hazard  = (r[5:0] == 6'd0);
        r              = rand_bits(`IW_CONTEXT_W);
        hazard_context = r[`IW_CONTEXT_W-1:0];
    endtask

    task automatic finish_run();
        $display("Result: %0d mismatches, %0d other errors, %0d timeouts",
                 mismatch_count, error_count, int'(timed_out));
        if (mismatch_count + error_count + int'(timed_out) == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        int sent;
        int waited;
        lfsr            = 32'h9279_e1a4;
        rst             = 1'b1;
        d_done          = 1'b0;
        d_dec_exec_info = '0;
        branch_hazard   = 1'b0;
        hazard_context  = '0;
        accepted        = 1'b0;
        took            = 1'b0;
        timed_out       = 1'b0;
        hold_left       = 0;
        sent            = 0;
        waited          = 0;
        // even vregs start ready
        vreg_ready = 32'h5555_5555;
        for (int i = 0; i < 32; i++) begin
            vreg_val[i] = rand_bits(32);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        while (sent < NUM_INST && !timed_out) begin
            step_cycle();
            if (took) begin
                sent   = sent + 1;
                waited = 0;
                // exec stalls for 20 cycles halfway through
                if (sent == NUM_INST / 2) begin
                    hold_left = 20;
                end
            end
            if (!d_done && sent < NUM_INST) begin
                new_instruction();
            end
            if (d_done) begin
                waited = waited + 1;
                if (waited > WAIT_LIMIT) begin
                    $display("Error: decode entry %0d was not taken within %0d cycles",
                             sent, WAIT_LIMIT);
                    timed_out = 1'b1;
                end
            end
        end

        waited = 0;
        while (pending != 0 && !timed_out) begin
            step_cycle();
            waited = waited + 1;
            if (waited > DRAIN_LIMIT) begin
                $display("Error: %0d instructions still in the window after %0d cycles",
                         pending, DRAIN_LIMIT);
                timed_out = 1'b1;
            end
        end
        // a few idle cycles so a duplicate issue would still show up
        if (!timed_out) begin
            repeat (10) step_cycle();
        end
        finish_run();
    end

endmodule

// ==== inst_window.f ====
+incdir+source
source/iw_pkg.sv
source/issue_select.sv
source/window_compact.sv
source/operand_resolve.sv
source/slot_array.sv
source/inst_window.sv
testbench/tb_checker.sv
testbench/tb_inst_window.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_inst_window \
    -f inst_window.f -o sim_inst_window
./obj_dir/sim_inst_window | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: test passed"
else
    echo "run_sim: test failed, see sim.log"
    exit 1
fi
